// ==== Makefile ====
# Verilator build for the CP0 testbench
VERILATOR ?= verilator
TOP       ?= tb_cp0
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SOURCES   ?= $(wildcard source/*.sv verif/*.sv verif/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== list.f ====
+incdir+verif
source/cp0_pkg.sv
source/cycle_timer.sv
source/irq_ctrl.sv
source/cp0_regs.sv
source/pc_sequencer.sv
source/cp0_top.sv
verif/tb_cp0.sv

// ==== source/cp0_pkg.sv ====
package cp0_pkg;

    // One CP0 operation per cycle, driven by the core
    typedef enum logic [1:0] {
        CP0_NOP  = 2'd0,  // No CP0 activity
        CP0_MTC0 = 2'd1,  // Write wr_data to register regnum
        CP0_ERET = 2'd2   // Return from exception
    } cp0_op_e;

    // Architectural register numbers
    localparam logic [4:0] REG_COUNT   = 5'd9;
    localparam logic [4:0] REG_COMPARE = 5'd11;
    localparam logic [4:0] REG_STATUS  = 5'd12;
    localparam logic [4:0] REG_CAUSE   = 5'd13;
    localparam logic [4:0] REG_EPC     = 5'd14;

    // Status register fields
    localparam int ST_IE       = 0;   // Global interrupt enable
    localparam int ST_EXL      = 1;   // Exception level
    localparam int ST_IM_TIMER = 15;  // Timer line inside the mask byte

    // Cause register fields
    localparam int CAUSE_IP_TIMER = 15;  // Timer interrupt pending

endpackage

// ==== source/cp0_regs.sv ====
`timescale 1ns/1ns

module cp0_regs
    import cp0_pkg::*;
#(
    parameter int ADDR_WIDTH = 64
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  cp0_op_e               op,
    input  logic [4:0]            regnum,
    input  logic [ADDR_WIDTH-1:0] wr_data,
    input  logic                  taken_interrupt,
    input  logic [ADDR_WIDTH-1:0] resume_pc,
    input  logic                  exl,
    input  logic [31:0]           cause_word,
    input  logic [ADDR_WIDTH-1:0] count,
    output logic [ADDR_WIDTH-1:0] rd_data,
    output logic                  status_ie,
    output logic                  status_im_timer,
    output logic [ADDR_WIDTH-1:0] compare,
    output logic                  compare_write,
    output logic [ADDR_WIDTH-3:0] epc_word
);

    localparam int IM_LSB = 8;  // Interrupt mask occupies status[15:8]

    logic [7:0] status_im;
    logic       mtc0;
    logic       status_write;
    logic       epc_write;

    // Write decode
    assign mtc0          = (op == CP0_MTC0);
    assign status_write  = mtc0 && (regnum == REG_STATUS);
    assign epc_write     = mtc0 && (regnum == REG_EPC);
    assign compare_write = mtc0 && (regnum == REG_COMPARE);

    assign status_im_timer = status_im[ST_IM_TIMER - IM_LSB];

    // Status keeps the mask byte and IE only
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            status_im <= '0;
            status_ie <= 1'b0;
        end else if (status_write) begin
            status_im <= wr_data[IM_LSB +: 8];
            status_ie <= wr_data[ST_IE];
        end
    end

    // EPC holds a word address
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            epc_word <= '0;
        end else if (taken_interrupt) begin
            epc_word <= resume_pc[ADDR_WIDTH-1:2];  // Instruction that did not retire
        end else if (epc_write) begin
            epc_word <= wr_data[ADDR_WIDTH-1:2];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            compare <= '0;
        end else if (compare_write) begin
            compare <= wr_data;
        end
    end

    // Read multiplexer, combinational on regnum
    always_comb begin
        rd_data = '0;
        case (regnum)
            REG_STATUS: begin
                rd_data[IM_LSB +: 8] = status_im;
                rd_data[ST_EXL]      = exl;
                rd_data[ST_IE]       = status_ie;
            end
            REG_CAUSE: begin
                rd_data[31:0] = cause_word;
            end
            REG_EPC: begin
                rd_data = {epc_word, 2'b00};
            end
            REG_COUNT: begin
                rd_data = count;
            end
            REG_COMPARE: begin
                rd_data = compare;
            end
            default: begin
                rd_data = '0;  // Unimplemented registers read as zero
            end
        endcase
    end

    // The opcode must always be one of the defined encodings
    a_op_legal : assert property (
        @(posedge clock) disable iff (!arst_n)
        !$isunknown(op) && (op inside {CP0_NOP, CP0_MTC0, CP0_ERET})
    ) else $error("illegal or unknown CP0 opcode %b", op);

endmodule

// ==== source/cp0_top.sv ====
`timescale 1ns/1ns

module cp0_top
    import cp0_pkg::*;
#(
    parameter int                    ADDR_WIDTH     = 64,
    parameter logic [ADDR_WIDTH-1:0] HANDLER_VECTOR = 'h180,
    parameter logic [ADDR_WIDTH-1:0] RESET_VECTOR   = '0
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  cp0_op_e               op,
    input  logic [4:0]            regnum,
    input  logic [ADDR_WIDTH-1:0] wr_data,
    input  logic                  step,
    output logic [ADDR_WIDTH-1:0] pc,
    output logic [ADDR_WIDTH-1:0] rd_data,
    output logic [ADDR_WIDTH-1:0] epc,
    output logic                  taken_interrupt
);

    logic                  status_ie;
    logic                  status_im_timer;
    logic [ADDR_WIDTH-1:0] compare;
    logic                  compare_write;
    logic [ADDR_WIDTH-3:0] epc_word;
    logic [ADDR_WIDTH-1:0] count;
    logic                  timer_pending;
    logic                  exl;
    logic [31:0]           cause_word;

    assign epc = {epc_word, 2'b00};  // Byte address view

    cycle_timer #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_cycle_timer (
        .clock         (clock),
        .arst_n        (arst_n),
        .compare       (compare),
        .compare_write (compare_write),
        .count         (count),
        .timer_pending (timer_pending)
    );

    irq_ctrl u_irq_ctrl (
        .clock           (clock),
        .arst_n          (arst_n),
        .op              (op),
        .timer_pending   (timer_pending),
        .status_ie       (status_ie),
        .status_im_timer (status_im_timer),
        .taken_interrupt (taken_interrupt),
        .exl             (exl),
        .cause_word      (cause_word)
    );

    cp0_regs #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_cp0_regs (
        .clock           (clock),
        .arst_n          (arst_n),
        .op              (op),
        .regnum          (regnum),
        .wr_data         (wr_data),
        .taken_interrupt (taken_interrupt),
        .resume_pc       (pc),
        .exl             (exl),
        .cause_word      (cause_word),
        .count           (count),
        .rd_data         (rd_data),
        .status_ie       (status_ie),
        .status_im_timer (status_im_timer),
        .compare         (compare),
        .compare_write   (compare_write),
        .epc_word        (epc_word)
    );

    pc_sequencer #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .HANDLER_VECTOR (HANDLER_VECTOR),
        .RESET_VECTOR   (RESET_VECTOR)
    ) u_pc_sequencer (
        .clock           (clock),
        .arst_n          (arst_n),
        .op              (op),
        .step            (step),
        .taken_interrupt (taken_interrupt),
        .epc_word        (epc_word),
        .pc              (pc)
    );

endmodule

// ==== source/cycle_timer.sv ====
`timescale 1ns/1ns

module cycle_timer #(
    parameter int ADDR_WIDTH = 64
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [ADDR_WIDTH-1:0] compare,
    input  logic                  compare_write,
    output logic [ADDR_WIDTH-1:0] count,
    output logic                  timer_pending
);

    logic match;

    assign match = (count == compare);

    // Free-running cycle counter
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Sticky pending flag, cleared only by a new compare value
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            timer_pending <= 1'b0;
        end else if (compare_write) begin
            timer_pending <= 1'b0;  // Write wins over a match on the same edge
        end else if (match) begin
            timer_pending <= 1'b1;
        end
    end

    // The flag rises only after a count match on an edge with no compare write
    a_pending_rise : assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(timer_pending) |-> $past(count == compare) && !$past(compare_write)
    ) else $error("timer_pending rose without a match or on a compare write edge");

endmodule

// ==== source/irq_ctrl.sv ====
`timescale 1ns/1ns

module irq_ctrl
    import cp0_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  cp0_op_e     op,
    input  logic        timer_pending,
    input  logic        status_ie,
    input  logic        status_im_timer,
    output logic        taken_interrupt,
    output logic        exl,
    output logic [31:0] cause_word
);

    // Take the timer line only when unmasked, enabled and not already in a handler
    assign taken_interrupt = timer_pending & status_im_timer & status_ie & ~exl;

    always_comb begin
        cause_word = '0;
        cause_word[CAUSE_IP_TIMER] = timer_pending;
    end

    // Exception level
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            exl <= 1'b0;
        end else if (taken_interrupt) begin
            exl <= 1'b1;  // Entry beats a same-cycle ERET
        end else if (op == CP0_ERET) begin
            exl <= 1'b0;
        end
    end

    // EXL must block a second take straight after the first
    a_take_one_cycle : assert property (
        @(posedge clock) disable iff (!arst_n)
        taken_interrupt |=> !taken_interrupt
    ) else $error("taken_interrupt high on two consecutive cycles");

endmodule

// ==== source/pc_sequencer.sv ====
`timescale 1ns/1ns

module pc_sequencer
    import cp0_pkg::*;
#(
    parameter int                    ADDR_WIDTH     = 64,
    parameter logic [ADDR_WIDTH-1:0] HANDLER_VECTOR = 'h180,
    parameter logic [ADDR_WIDTH-1:0] RESET_VECTOR   = '0
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  cp0_op_e               op,
    input  logic                  step,
    input  logic                  taken_interrupt,
    input  logic [ADDR_WIDTH-3:0] epc_word,
    output logic [ADDR_WIDTH-1:0] pc
);

    logic [ADDR_WIDTH-1:0] pc_next;

    // Interrupt first, then ERET, then retirement
    always_comb begin
        if (taken_interrupt) begin
            pc_next = HANDLER_VECTOR;
        end else if (op == CP0_ERET) begin
            pc_next = {epc_word, 2'b00};
        end else if (step) begin
            pc_next = pc + ADDR_WIDTH'(4);
        end else begin
            pc_next = pc;  // Stall
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= pc_next;
        end
    end

    // Vectors and EPC are all word aligned, so pc never leaves alignment
    a_pc_aligned : assert property (
        @(posedge clock) disable iff (!arst_n)
        pc[1:0] == 2'b00
    ) else $error("pc misaligned: %h", pc);

endmodule

// ==== verif/tb_cp0_tasks.svh ====
// Inputs change 2 ns after the rising edge and hold for one cycle
task automatic drive_cycle(input cp0_op_e next_op, input logic [4:0] next_reg,
                           input logic [ADDR_WIDTH-1:0] next_data, input logic next_step);
    @(posedge clock);
    #2;
    op      = next_op;
    regnum  = next_reg;
    wr_data = next_data;
    step    = next_step;
endtask

task automatic do_mtc0(input logic [4:0] reg_sel, input logic [ADDR_WIDTH-1:0] data);
    drive_cycle(CP0_MTC0, reg_sel, data, 1'b0);
endtask

task automatic do_eret();
    drive_cycle(CP0_ERET, 5'd0, '0, 1'b0);
endtask

task automatic do_step();
    drive_cycle(CP0_NOP, 5'd0, '0, 1'b1);
endtask

task automatic do_idle();
    drive_cycle(CP0_NOP, 5'd0, '0, 1'b0);
endtask

task automatic settle();
    #8;  // Mid cycle, well clear of both edges
endtask

task automatic read_reg(input logic [4:0] reg_sel, output logic [ADDR_WIDTH-1:0] data);
    drive_cycle(CP0_NOP, reg_sel, '0, 1'b0);
    settle();
    data = rd_data;
endtask

task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] expected,
                          input logic [ADDR_WIDTH-1:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
    end
endtask

task automatic check_data(input string name, input logic [ADDR_WIDTH-1:0] expected,
                          input logic [ADDR_WIDTH-1:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
    end
endtask

task automatic note_failure(input string what);
    error_count++;
    $display("%s", what);
endtask

task automatic test_reset();
    logic [ADDR_WIDTH-1:0] value;
    // count equals compare out of reset, so cause is only clear before the first edge
    regnum = REG_CAUSE;
    settle();
    check_data("cause after reset", '0, rd_data);
    check_addr("pc after reset", RESET_VECTOR, pc);
    check_bit("taken_interrupt after reset", 1'b0, taken_interrupt);
    read_reg(REG_CAUSE, value);
    check_data("cause after first match", CAUSE_TIMER, value);
    read_reg(REG_STATUS, value);
    check_data("status after reset", '0, value);
    read_reg(REG_EPC, value);
    check_data("epc after reset", '0, value);
    read_reg(REG_COMPARE, value);
    check_data("compare after reset", '0, value);
    read_reg(5'd5, value);
    check_data("register 5 after reset", '0, value);
endtask

task automatic test_write_read();
    logic [ADDR_WIDTH-1:0] data;
    logic [ADDR_WIDTH-1:0] value;
    // Top bit set keeps compare far ahead of count
    data = random_word() | (ADDR_WIDTH'(1) << (ADDR_WIDTH - 1));
    do_mtc0(REG_COMPARE, data);
    read_reg(REG_COMPARE, value);
    check_data("compare readback", data, value);
    data = random_word();
    do_mtc0(REG_EPC, data);
    read_reg(REG_EPC, value);
    check_data("epc readback", data & ~ADDR_WIDTH'(3), value);
    check_addr("epc", data & ~ADDR_WIDTH'(3), epc);
    data = random_word();
    do_mtc0(REG_STATUS, data);
    read_reg(REG_STATUS, value);
    check_data("status readback", data & STATUS_VIEW, value);
    read_reg(5'd5, value);
    check_data("register 5", '0, value);
endtask

task automatic test_step_and_count();
    int                    n;
    int                    m;
    logic [ADDR_WIDTH-1:0] first;
    logic [ADDR_WIDTH-1:0] second;
    n = int'(xorshift32() % 32'd16) + 1;
    repeat (n) do_step();
    do_idle();
    settle();
    pc_model = pc_model + ADDR_WIDTH'(4 * n);
    check_addr("pc after steps", pc_model, pc);
    m = int'(xorshift32() % 32'd8) + 2;
    read_reg(REG_COUNT, first);
    repeat (m - 1) do_idle();  // Second read lands m cycles after the first
    read_reg(REG_COUNT, second);
    check_data("count difference", ADDR_WIDTH'(m), second - first);
endtask

task automatic test_masked_timer();
    logic [ADDR_WIDTH-1:0] now;
    logic [ADDR_WIDTH-1:0] value;
    logic                  seen;
    int                    i;
    seen = 1'b0;
    do_mtc0(REG_STATUS, ADDR_WIDTH'(1) << ST_IE);
    read_reg(REG_COUNT, now);
    do_mtc0(REG_COMPARE, now + ADDR_WIDTH'(20));
    for (i = 0; i < 40 && !seen; i++) begin
        read_reg(REG_CAUSE, value);
        check_bit("taken_interrupt while masked", 1'b0, taken_interrupt);
        seen = (value == CAUSE_TIMER);
    end
    if (!seen) begin
        note_failure("Cause never showed the timer bit within 40 cycles of the compare write");
    end
endtask

task automatic test_take_interrupt();
    logic [ADDR_WIDTH-1:0] value;
    do_mtc0(REG_STATUS, STATUS_TIMER_ON);
    do_step();  // Retirement in the take cycle loses to the interrupt
    settle();
    check_bit("taken_interrupt on take", 1'b1, taken_interrupt);
    check_addr("pc on take", pc_model, pc);
    saved_epc = pc_model;
    do_idle();
    settle();
    check_bit("taken_interrupt after take", 1'b0, taken_interrupt);
    check_addr("pc after take", HANDLER_VECTOR, pc);
    check_addr("epc after take", saved_epc, epc);
    pc_model = HANDLER_VECTOR;
    read_reg(REG_STATUS, value);
    check_data("status in handler", STATUS_TIMER_ON | STATUS_EXL, value);
    repeat (20) begin
        read_reg(REG_CAUSE, value);
        check_data("cause in handler", CAUSE_TIMER, value);
        check_bit("taken_interrupt in handler", 1'b0, taken_interrupt);
    end
endtask

task automatic test_eret();
    logic [ADDR_WIDTH-1:0] value;
    do_mtc0(REG_COMPARE, ~ADDR_WIDTH'(0));
    read_reg(REG_CAUSE, value);
    check_data("cause after compare write", '0, value);
    do_eret();
    do_idle();
    settle();
    check_addr("pc after eret", saved_epc, pc);
    pc_model = saved_epc;
    read_reg(REG_STATUS, value);
    check_data("status after eret", STATUS_TIMER_ON, value);
    repeat (20) begin
        do_idle();
        settle();
        check_bit("taken_interrupt after eret", 1'b0, taken_interrupt);
    end
endtask

// ==== verif/tb_cp0.sv ====
`timescale 1ns/1ns

module tb_cp0
    import cp0_pkg::*;
;

    localparam int                    ADDR_WIDTH     = 64;
    localparam logic [ADDR_WIDTH-1:0] HANDLER_VECTOR = 'h180;
    localparam logic [ADDR_WIDTH-1:0] RESET_VECTOR   = '0;

    // Expected read views
    localparam logic [ADDR_WIDTH-1:0] CAUSE_TIMER = ADDR_WIDTH'(1) << CAUSE_IP_TIMER;
    localparam logic [ADDR_WIDTH-1:0] STATUS_VIEW = 'hFF01;  // Mask byte and IE
    localparam logic [ADDR_WIDTH-1:0] STATUS_EXL  = ADDR_WIDTH'(1) << ST_EXL;
    localparam logic [ADDR_WIDTH-1:0] STATUS_TIMER_ON =
        (ADDR_WIDTH'(1) << ST_IM_TIMER) | (ADDR_WIDTH'(1) << ST_IE);

    // The directed tests finish in a few hundred cycles
    localparam int MAX_CYCLES = 3000;

    logic                  clock;
    logic                  arst_n;
    cp0_op_e               op;
    logic [4:0]            regnum;
    logic [ADDR_WIDTH-1:0] wr_data;
    logic                  step;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] rd_data;
    logic [ADDR_WIDTH-1:0] epc;
    logic                  taken_interrupt;

    int                    check_count = 0;
    int                    error_count = 0;
    int                    cycle_count = 0;
    logic [31:0]           rng_state   = 32'd81271;
    logic [ADDR_WIDTH-1:0] pc_model;   // Expected pc outside the handler
    logic [ADDR_WIDTH-1:0] saved_epc;  // pc captured by the last take

    cp0_top UUT (
        .clock           (clock),
        .arst_n          (arst_n),
        .op              (op),
        .regnum          (regnum),
        .wr_data         (wr_data),
        .step            (step),
        .pc              (pc),
        .rd_data         (rd_data),
        .epc             (epc),
        .taken_interrupt (taken_interrupt)
    );

    initial begin
        clock = 1'b0;
    end

    always #20 clock = ~clock;  // 40 ns period

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Shift register generator with a fixed seed
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] random_word();
        logic [31:0] upper;
        logic [31:0] lower;
        upper = xorshift32();
        lower = xorshift32();
        return ADDR_WIDTH'({upper, lower});
    endfunction

    `include "tb_cp0_tasks.svh"

    initial begin
        arst_n    = 1'b0;
        op        = CP0_NOP;
        regnum    = 5'd0;
        wr_data   = '0;
        step      = 1'b0;
        pc_model  = RESET_VECTOR;
        saved_epc = '0;

        repeat (3) @(posedge clock);
        #2;
        arst_n = 1'b1;

        test_reset();
        test_write_read();
        test_step_and_count();
        test_masked_timer();
        test_take_interrupt();
        test_eret();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
